//--- verilog/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// datapath
`define OOO_XLEN      32
`define OOO_REG_AW    5

// reorder buffer, depth must stay 2**OOO_TAG_W
`define OOO_ROB_DEPTH 8
`define OOO_TAG_W     3

// one partial product per cycle
`define OOO_MUL_STEPS 32

`endif

//--- verilog/ooo_pkg.sv
`include "ooo_macros.svh"

package ooo_pkg;

   // dispatch op codes
   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4,
      OP_SLL = 3'd5,
      OP_SRL = 3'd6,
      OP_MUL = 3'd7   // iterative, low half only
   } op_e;

   typedef logic [`OOO_XLEN-1:0]   data_t;
   typedef logic [`OOO_REG_AW-1:0] reg_addr_t;
   typedef logic [`OOO_TAG_W-1:0]  rob_tag_t;

endpackage

//--- verilog/rob_if.sv
interface rob_if;

   // allocation, one entry per accepted op
   logic               alloc_valid;
   ooo_pkg::reg_addr_t alloc_rd;
   logic               alloc_ready;   // not full
   ooo_pkg::rob_tag_t  alloc_tag;     // tail index

   // completion pulse, entry already reserved
   logic               cpl_valid;
   ooo_pkg::rob_tag_t  cpl_tag;
   ooo_pkg::data_t     cpl_data;

   modport exec (
      output alloc_valid, alloc_rd, cpl_valid, cpl_tag, cpl_data,
      input  alloc_ready, alloc_tag
   );

   modport rob (
      input  alloc_valid, alloc_rd, cpl_valid, cpl_tag, cpl_data,
      output alloc_ready, alloc_tag
   );

endinterface

//--- verilog/exec_unit.sv
`include "ooo_macros.svh"

module exec_unit (
   input  logic               clk,
   input  logic               rst,
   input  logic               cyc,
   input  logic               stb,
   input  ooo_pkg::op_e       op,
   input  ooo_pkg::reg_addr_t rd,
   input  ooo_pkg::data_t     a,
   input  ooo_pkg::data_t     b,
   output logic               ack,
   rob_if.exec                rif
);

   localparam int STEP_W = $clog2(`OOO_MUL_STEPS);
   localparam int SH_W   = $clog2(`OOO_XLEN);

   ooo_pkg::op_e       op_q;
   ooo_pkg::reg_addr_t rd_q;
   ooo_pkg::data_t     a_q;
   ooo_pkg::data_t     b_q;
   ooo_pkg::data_t     alu_res;
   logic               accept;
   logic               alu_fire;
   logic               mul_fire;

   logic               mul_busy;
   logic [STEP_W-1:0]  mul_step;
   logic               mul_last;
   ooo_pkg::data_t     mul_acc;
   ooo_pkg::data_t     mul_mcand;
   ooo_pkg::data_t     mul_mplier;
   ooo_pkg::data_t     mul_next;
   ooo_pkg::rob_tag_t  mul_tag;

   logic               hold_valid;
   ooo_pkg::data_t     hold_data;
   ooo_pkg::rob_tag_t  hold_tag;
   logic               cpl_valid_q;
   ooo_pkg::data_t     cpl_data_q;
   ooo_pkg::rob_tag_t  cpl_tag_q;

   // no new op while ack is out, rob full, hold busy or mul unit taken
   assign accept = cyc && stb && !ack && rif.alloc_ready && !hold_valid &&
                   !(op == ooo_pkg::OP_MUL && mul_busy);

   assign alu_fire = ack && (op_q != ooo_pkg::OP_MUL);
   assign mul_fire = ack && (op_q == ooo_pkg::OP_MUL);

   assign rif.alloc_valid = ack;   // tag claimed in the ack cycle
   assign rif.alloc_rd    = rd_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         ack <= 1'b0;
      end else begin
         ack <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op_q <= op;
         rd_q <= rd;
         a_q  <= a;
         b_q  <= b;
      end
   end

   always_comb begin
      unique case (op_q)
         ooo_pkg::OP_ADD: alu_res = a_q + b_q;
         ooo_pkg::OP_SUB: alu_res = a_q - b_q;
         ooo_pkg::OP_AND: alu_res = a_q & b_q;
         ooo_pkg::OP_OR:  alu_res = a_q | b_q;
         ooo_pkg::OP_XOR: alu_res = a_q ^ b_q;
         ooo_pkg::OP_SLL: alu_res = a_q << b_q[SH_W-1:0];
         ooo_pkg::OP_SRL: alu_res = a_q >> b_q[SH_W-1:0];
         default:         alu_res = '0;   // mul goes to the shift-add unit
      endcase
   end

   // shift-add multiplier, one bit of b per cycle
   assign mul_next = mul_mplier[0] ? mul_acc + mul_mcand : mul_acc;
   assign mul_last = mul_busy && (mul_step == STEP_W'(`OOO_MUL_STEPS - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         mul_busy <= 1'b0;
         mul_step <= '0;
      end else if (accept && op == ooo_pkg::OP_MUL) begin
         mul_busy <= 1'b1;
         mul_step <= '0;
      end else if (mul_busy) begin
         mul_busy <= !mul_last;
         mul_step <= mul_step + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && op == ooo_pkg::OP_MUL) begin
         mul_acc    <= '0;
         mul_mcand  <= a;
         mul_mplier <= b;
      end else if (mul_busy) begin
         mul_acc    <= mul_next;
         mul_mcand  <= mul_mcand << 1;
         mul_mplier <= mul_mplier >> 1;
      end
      if (mul_fire) begin
         mul_tag <= rif.alloc_tag;
      end
   end

   // completion bus, mul > hold > fresh alu result
   always_ff @(posedge clk) begin
      if (rst) begin
         cpl_valid_q <= 1'b0;
         hold_valid  <= 1'b0;
      end else begin
         cpl_valid_q <= mul_last || hold_valid || alu_fire;
         hold_valid  <= mul_last && alu_fire;   // alu loses, retry next cycle
      end
   end

   always_ff @(posedge clk) begin
      if (mul_last) begin
         cpl_data_q <= mul_next;
         cpl_tag_q  <= mul_tag;
      end else if (hold_valid) begin
         cpl_data_q <= hold_data;
         cpl_tag_q  <= hold_tag;
      end else begin
         cpl_data_q <= alu_res;
         cpl_tag_q  <= rif.alloc_tag;
      end
      if (alu_fire) begin
         hold_data <= alu_res;
         hold_tag  <= rif.alloc_tag;
      end
   end

   assign rif.cpl_valid = cpl_valid_q;
   assign rif.cpl_tag   = cpl_tag_q;
   assign rif.cpl_data  = cpl_data_q;

endmodule

//--- verilog/reorder_buffer.sv
`include "ooo_macros.svh"

module reorder_buffer (
   input  logic               clk,
   input  logic               rst,
   rob_if.rob                 rif,
   output logic               retire_valid,
   output ooo_pkg::reg_addr_t retire_rd,
   output ooo_pkg::data_t     retire_data
);

   localparam int                CNT_W = `OOO_TAG_W + 1;
   localparam logic [CNT_W-1:0] FULL  = CNT_W'(`OOO_ROB_DEPTH);

   ooo_pkg::reg_addr_t        rd_mem   [`OOO_ROB_DEPTH];
   ooo_pkg::data_t            data_mem [`OOO_ROB_DEPTH];
   logic [`OOO_ROB_DEPTH-1:0] done;

   ooo_pkg::rob_tag_t         head;
   ooo_pkg::rob_tag_t         tail;
   logic [CNT_W-1:0]          count;
   logic                      do_alloc;

   assign rif.alloc_ready = (count != FULL);
   assign rif.alloc_tag   = tail;
   assign do_alloc        = rif.alloc_valid && rif.alloc_ready;

   // head leaves as soon as its result is in
   assign retire_valid = done[head];
   assign retire_rd    = rd_mem[head];
   assign retire_data  = data_mem[head];

   always_ff @(posedge clk) begin
      if (rst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         done  <= '0;
      end else begin
         if (do_alloc) begin
            tail <= tail + 1'b1;   // wraps at depth
         end
         if (retire_valid) begin
            head       <= head + 1'b1;
            done[head] <= 1'b0;    // slot free for the next allocation
         end
         if (rif.cpl_valid) begin
            done[rif.cpl_tag] <= 1'b1;
         end
         count <= count + CNT_W'(do_alloc) - CNT_W'(retire_valid);
      end
   end

   always_ff @(posedge clk) begin
      if (do_alloc) begin
         rd_mem[tail] <= rif.alloc_rd;
      end
      if (rif.cpl_valid) begin
         data_mem[rif.cpl_tag] <= rif.cpl_data;
      end
   end

endmodule

//--- verilog/arch_regfile.sv
`include "ooo_macros.svh"

module arch_regfile (
   input  logic               clk,
   input  logic               rst,
   input  logic               we,
   input  ooo_pkg::reg_addr_t waddr,
   input  ooo_pkg::data_t     wdata,
   input  ooo_pkg::reg_addr_t raddr,
   output ooo_pkg::data_t     rdata
);

   localparam int NREGS = 2 ** `OOO_REG_AW;

   ooo_pkg::data_t regs [NREGS];

   // committed state only, written from the retire port
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && waddr != '0) begin   // x0 stays zero
         regs[waddr] <= wdata;
      end
   end

   assign rdata = regs[raddr];

endmodule

//--- verilog/ooo_retire_top.sv
module ooo_retire_top (
   input  logic               clk,
   input  logic               rst,

   // wishbone classic dispatch
   input  logic               cyc,
   input  logic               stb,
   input  ooo_pkg::op_e       op,
   input  ooo_pkg::reg_addr_t rd,
   input  ooo_pkg::data_t     a,
   input  ooo_pkg::data_t     b,
   output logic               ack,

   output logic               retire_valid,
   output ooo_pkg::reg_addr_t retire_rd,
   output ooo_pkg::data_t     retire_data,

   input  ooo_pkg::reg_addr_t rf_addr,
   output ooo_pkg::data_t     rf_data
);

   rob_if i_rob_if ();

   exec_unit i_exec (
      .clk (clk),
      .rst (rst),
      .cyc (cyc),
      .stb (stb),
      .op  (op),
      .rd  (rd),
      .a   (a),
      .b   (b),
      .ack (ack),
      .rif (i_rob_if.exec)
   );

   reorder_buffer i_rob (
      .clk          (clk),
      .rst          (rst),
      .rif          (i_rob_if.rob),
      .retire_valid (retire_valid),
      .retire_rd    (retire_rd),
      .retire_data  (retire_data)
   );

   // retire stream doubles as the regfile write port
   arch_regfile i_rf (
      .clk   (clk),
      .rst   (rst),
      .we    (retire_valid),
      .waddr (retire_rd),
      .wdata (retire_data),
      .raddr (rf_addr),
      .rdata (rf_data)
   );

endmodule

//--- dv/ooo_retire_assert.sv
`include "ooo_macros.svh"

module ooo_retire_assert (
   input logic                clk,
   input logic                rst,
   input logic                stb,
   input logic                ack,
   input logic                retire_valid,
   input logic [`OOO_TAG_W:0] rob_count
);

   int fails = 0;

   // slave only acks a strobed cycle
   ack_needs_stb: assert property (@(posedge clk) disable iff (rst) ack |-> stb)
      else begin fails++; $error("ack high without stb"); end

   retire_quiet_in_reset: assert property (@(posedge clk) rst |=> !retire_valid)
      else begin fails++; $error("retire_valid high during reset"); end

   count_in_range: assert property (@(posedge clk) disable iff (rst)
      rob_count <= `OOO_ROB_DEPTH)
      else begin fails++; $error("rob count above depth"); end

endmodule

bind ooo_retire_top ooo_retire_assert i_assert (
   .clk          (clk),
   .rst          (rst),
   .stb          (stb),
   .ack          (ack),
   .retire_valid (retire_valid),
   .rob_count    (i_rob.count)
);

//--- dv/tb_ooo_retire.sv
`include "ooo_macros.svh"

module tb_ooo_retire;

   localparam int MAX_PAT = 32;
   localparam int COLS    = 5;
   localparam int NREGS   = 2 ** `OOO_REG_AW;

   logic               clk;
   logic               rst;
   logic               cyc;
   logic               stb;
   ooo_pkg::op_e       op;
   ooo_pkg::reg_addr_t rd;
   ooo_pkg::data_t     a;
   ooo_pkg::data_t     b;
   logic               ack;
   logic               retire_valid;
   ooo_pkg::reg_addr_t retire_rd;
   ooo_pkg::data_t     retire_data;
   ooo_pkg::reg_addr_t rf_addr;
   ooo_pkg::data_t     rf_data;

   logic [31:0]    pat [MAX_PAT*COLS];
   ooo_pkg::data_t shadow [NREGS];   // last value retired per rd
   int             exp_idx [$];      // pattern indices in dispatch order
   int             npat;
   int             errors;
   int             checks;
   int             acks;
   int             retired;

   ooo_retire_top i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic compare_data(input ooo_pkg::data_t got, input ooo_pkg::data_t exp,
                               input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compare_reg(input ooo_pkg::reg_addr_t got, input ooo_pkg::reg_addr_t exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
      end
   endtask

   // entered and left 2 units after a rising edge
   task automatic dispatch(input int idx);
      cyc = 1'b1;
      stb = 1'b1;
      op  = ooo_pkg::op_e'(pat[idx*COLS][2:0]);
      rd  = ooo_pkg::reg_addr_t'(pat[idx*COLS+1]);
      a   = pat[idx*COLS+2];
      b   = pat[idx*COLS+3];
      exp_idx.push_back(idx);
      do @(negedge clk); while (!ack);
      @(posedge clk);   // master samples ack here
      #2;
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   task automatic check_regfile(input string label);
      int err0;
      err0 = errors;
      for (int r = 0; r < NREGS; r++) begin
         rf_addr = ooo_pkg::reg_addr_t'(r);
         @(negedge clk);
         compare_data(rf_data, shadow[r], $sformatf("%s x%0d", label, r));
         @(posedge clk);
         #2;
      end
      $display("%s: %s", label, errors == err0 ? "ok" : "wrong");
   endtask

   task automatic watchdog(input int cycles);
      repeat (cycles) @(posedge clk);
      $display("timeout: operations still outstanding after %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
   endtask

   initial begin : retire_monitor
      int           idx;
      int           err0;
      ooo_pkg::op_e pop;
      forever begin
         @(negedge clk);
         if (!rst && ack) acks++;
         if (!rst && retire_valid) begin
            if (exp_idx.size() == 0) begin
               errors++;
               $display("retire at %0t with no operation in flight", $time);
            end else begin
               idx  = exp_idx.pop_front();
               err0 = errors;
               pop  = ooo_pkg::op_e'(pat[idx*COLS][2:0]);
               compare_reg(retire_rd, ooo_pkg::reg_addr_t'(pat[idx*COLS+1]),
                           $sformatf("pattern %0d rd", idx));
               compare_data(retire_data, pat[idx*COLS+4], $sformatf("pattern %0d data", idx));
               $display("pattern %0d %s x%0d = %h: %s", idx, pop.name(), retire_rd,
                        retire_data, errors == err0 ? "ok" : "wrong");
               retired++;
            end
         end
      end
   end

   initial begin
      int unused_seed;
      int gap;
      int err0;
      int mul_idx;
      unused_seed = $urandom(5886);
      rst = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      op = ooo_pkg::OP_ADD;
      rd = '0;
      a = '0;
      b = '0;
      rf_addr = '0;
      errors = 0;
      checks = 0;
      acks = 0;
      retired = 0;
      foreach (shadow[r]) shadow[r] = '0;
      $readmemh("dv/dispatch_patterns.txt", pat);
      npat = 0;
      while (npat < MAX_PAT && !$isunknown(pat[npat*COLS])) npat++;
      fork
         watchdog(npat * (`OOO_MUL_STEPS + 10) + 100);
      join_none
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;

      for (int i = 0; i < npat; i++) begin
         gap = $urandom % 4;
         repeat (gap) begin
            @(posedge clk);
            #2;
         end
         dispatch(i);
         if (pat[i*COLS+1][4:0] != '0) shadow[pat[i*COLS+1][4:0]] = pat[i*COLS+4];
      end
      while (exp_idx.size() != 0) @(negedge clk);
      if (acks != npat) begin
         errors++;
         $display("CHECK FAILED at %0t: %0d acks for %0d operations", $time, acks, npat);
      end
      @(posedge clk);
      #2;
      check_regfile("register file");

      // first multiply in the list, an add behind it
      mul_idx = 0;
      for (int i = npat - 1; i >= 0; i--) begin
         if (ooo_pkg::op_e'(pat[i*COLS][2:0]) == ooo_pkg::OP_MUL) mul_idx = i;
      end

      // mid-run reset with both still in flight
      dispatch(mul_idx);
      dispatch(0);
      rst = 1'b1;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      exp_idx.delete();
      err0 = errors;
      repeat (`OOO_MUL_STEPS + 4) begin
         @(negedge clk);
         if (retire_valid !== 1'b0) begin
            errors++;
            $display("retire_valid high at %0t after reset with nothing dispatched", $time);
         end
      end
      $display("reset with operations in flight: %s", errors == err0 ? "ok" : "wrong");
      @(posedge clk);
      #2;
      foreach (shadow[r]) shadow[r] = '0;
      check_regfile("registers after reset");
      dispatch(0);
      while (exp_idx.size() != 0) @(negedge clk);

      if (i_dut.i_assert.fails != 0) begin
         errors += i_dut.i_assert.fails;
         $display("%0d assertion failures in the bound checker", i_dut.i_assert.fails);
      end
      $display("%0d checks, %0d errors, %0d operations retired", checks, errors, retired);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- dv/dispatch_patterns.txt
// op rd a b expected, all hex
// op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 mul
0 01 00000005 00000003 00000008
1 02 00000003 00000005 fffffffe
2 03 f0f0ff00 0ff0f0f0 00f0f000
3 04 f0f00000 00000f0f f0f00f0f
4 05 aaaa5555 ffff0000 55555555
5 06 00000001 0000001f 80000000
6 07 80000000 00000004 08000000
0 00 00000011 00000022 00000033
7 08 00012345 00006789 75cca2ed
0 09 00000100 00000001 00000101
1 0a 00000000 00000001 ffffffff
4 0b 12345678 ffffffff edcba987
5 0d 0000ffff 00000010 ffff0000
3 01 12340000 00005678 12345678
2 02 ffffffff 0000abcd 0000abcd
6 0e ffffffff 0000001f 00000001
0 09 ffffffff 00000002 00000001
7 0c ffffffff ffffffff 00000001
7 0f 80000000 00000003 80000000
7 10 00010000 00010000 00000000

//--- ooo_retire_top.f
+incdir+verilog
verilog/ooo_pkg.sv
verilog/rob_if.sv
verilog/exec_unit.sv
verilog/reorder_buffer.sv
verilog/arch_regfile.sv
verilog/ooo_retire_top.sv
dv/ooo_retire_assert.sv
dv/tb_ooo_retire.sv

//--- Bender.yml
package:
  name: ooo_retire

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ooo_pkg.sv
      - verilog/rob_if.sv
      - verilog/exec_unit.sv
      - verilog/reorder_buffer.sv
      - verilog/arch_regfile.sv
      - verilog/ooo_retire_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/ooo_retire_assert.sv
      - dv/tb_ooo_retire.sv
